//--- build.f
rtl/bridge_pkg.sv
rtl/rd_req_if.sv
rtl/wr_req_if.sv
rtl/port_arbiter.sv
rtl/read_engine.sv
rtl/write_engine.sv
rtl/sram_axi_bridge.sv
dv/tb_clock_gen.sv
dv/axi_mem_model.sv
dv/bridge_assertions.sv
dv/tb_sram_axi_bridge.sv

//--- dv/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model (
    input  logic                   aclk,
    input  logic                   reset,
    input  logic                   ar_valid,
    output logic                   ar_ready,
    input  bridge_pkg::addr_t      ar_addr,
    input  bridge_pkg::axi_len_t   ar_len,
    output logic                   r_valid,
    input  logic                   r_ready,
    output bridge_pkg::beat_t      r_data,
    output logic                   r_last,
    input  logic                   aw_valid,
    output logic                   aw_ready,
    input  bridge_pkg::addr_t      aw_addr,
    input  bridge_pkg::axi_len_t   aw_len,
    input  logic                   w_valid,
    output logic                   w_ready,
    input  bridge_pkg::beat_t      w_data,
    input  bridge_pkg::strb_t      w_strb,
    input  logic                   w_last,
    output logic                   b_valid,
    input  logic                   b_ready
);
    import bridge_pkg::*;

    beat_t mem [256];
    beat_t wbuf_data [4];
    strb_t wbuf_strb [4];
    int    seed = 32'hb54b;
    int    rd_ptr;
    int    rd_left;
    int    wr_ptr;
    int    wr_len;
    int    w_cnt;
    logic  aw_got;
    logic  w_got;

    // fill depends on the whole word index
    initial begin
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'hc3a50000 + (i * 32'h00010001);
        end
    end

    always @(posedge aclk) begin
        if (!reset) begin
            ar_ready <= 1'b0;
            r_valid <= 1'b0;
            r_data <= '0;
            r_last <= 1'b0;
            aw_ready <= 1'b0;
            w_ready <= 1'b0;
            b_valid <= 1'b0;
            rd_left = 0;
            wr_len = 0;
            w_cnt = 0;
            aw_got = 1'b0;
            w_got = 1'b0;
        end else begin
            // read address and beats
            if (ar_valid && ar_ready) begin
                rd_ptr = int'(ar_addr[9:2]);
                rd_left = int'(ar_len) + 1;
            end
            if (r_valid && r_ready) begin
                rd_ptr = (rd_ptr + 1) & 255;
                rd_left = rd_left - 1;
            end
            ar_ready <= (rd_left == 0) && !(ar_valid && ar_ready) && (($random(seed) & 3) != 0);
            if (r_valid && !r_ready) begin
                // hold beat under back-pressure
            end else if (rd_left > 0 && (($random(seed) & 3) != 0)) begin
                r_valid <= 1'b1;
                r_data <= mem[rd_ptr];
                r_last <= (rd_left == 1);
            end else begin
                r_valid <= 1'b0;
                r_last <= 1'b0;
            end
            // write address and beats, W may come first
            if (aw_valid && aw_ready) begin
                wr_ptr = int'(aw_addr[9:2]);
                // beats to commit come from the address phase
                wr_len = int'(aw_len) + 1;
                aw_got = 1'b1;
            end
            if (w_valid && w_ready) begin
                wbuf_data[w_cnt] = w_data;
                wbuf_strb[w_cnt] = w_strb;
                w_cnt = w_cnt + 1;
                if (w_last) begin
                    w_got = 1'b1;
                end
            end
            if (b_valid && b_ready) begin
                b_valid <= 1'b0;
            end
            // commit by strobe once both halves are in
            if (aw_got && w_got && !b_valid) begin
                for (int i = 0; i < wr_len; i++) begin
                    for (int k = 0; k < 4; k++) begin
                        if (wbuf_strb[i][k]) begin
                            mem[(wr_ptr + i) & 255][k*8 +: 8] = wbuf_data[i][k*8 +: 8];
                        end
                    end
                end
                b_valid <= 1'b1;
                aw_got = 1'b0;
                w_got = 1'b0;
                w_cnt = 0;
            end
            aw_ready <= !aw_got && (($random(seed) & 3) != 0);
            w_ready <= !w_got && (($random(seed) & 3) != 0);
        end
    end

endmodule

`default_nettype wire

//--- dv/bridge_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module bridge_assertions (
    input logic                 aclk,
    input logic                 reset,
    input logic                 ar_valid,
    input logic                 ar_ready,
    input bridge_pkg::addr_t    ar_addr,
    input bridge_pkg::axi_len_t ar_len,
    input logic                 aw_valid,
    input logic                 aw_ready,
    input bridge_pkg::addr_t    aw_addr,
    input bridge_pkg::axi_len_t aw_len,
    input logic                 w_valid,
    input logic                 w_ready,
    input bridge_pkg::beat_t    w_data,
    input bridge_pkg::strb_t    w_strb,
    input logic                 w_last
);
    import bridge_pkg::*;

    // W beats seen in the current burst
    axi_len_t w_cnt;

    always @(posedge aclk) begin
        if (!reset) begin
            w_cnt <= '0;
        end else if (w_valid && w_ready) begin
            w_cnt <= w_last ? '0 : w_cnt + 8'd1;
        end
    end

    ar_hold: assert property (@(posedge aclk) disable iff (!reset)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar_addr) && $stable(ar_len))
        else $error("AR payload changed before handshake");

    aw_hold: assert property (@(posedge aclk) disable iff (!reset)
        aw_valid && !aw_ready |=> aw_valid && $stable(aw_addr) && $stable(aw_len))
        else $error("AW payload changed before handshake");

    w_hold: assert property (@(posedge aclk) disable iff (!reset)
        w_valid && !w_ready |=> w_valid && $stable(w_data) && $stable(w_strb) && $stable(w_last))
        else $error("W payload changed before handshake");

    // last only on the final beat of the burst
    w_last_pos: assert property (@(posedge aclk) disable iff (!reset)
        w_valid |-> (w_last == (w_cnt == aw_len)))
        else $error("w_last on the wrong beat");

    rd_wr_excl: assert property (@(posedge aclk) disable iff (!reset)
        !(ar_valid && aw_valid))
        else $error("ar_valid and aw_valid high together");

endmodule

bind sram_axi_bridge bridge_assertions u_assertions (
    .aclk(aclk), .reset(reset),
    .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr), .ar_len(ar_len),
    .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr), .aw_len(aw_len),
    .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data), .w_strb(w_strb),
    .w_last(w_last)
);

`default_nettype wire

//--- dv/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic aclk,
    output logic reset
);
    // 20 ns period
    initial aclk = 1'b0;
    always #10 aclk = ~aclk;

    // active low for two edges, released on a falling edge
    initial begin
        reset = 1'b0;
        repeat (2) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b1;
    end

endmodule

`default_nettype wire

//--- dv/tb_sram_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sram_axi_bridge;
    import bridge_pkg::*;

    // 110 host transactions, 36 cycles each with room for stalls, plus reset and idle
    localparam int TXN_COUNT = 110;
    localparam int CYCLES_PER_TXN = 36;
    localparam int IDLE_CYCLES = 40;
    localparam int TIMEOUT_CYCLES = TXN_COUNT * CYCLES_PER_TXN + IDLE_CYCLES;

    logic aclk;
    logic reset;
    logic data_ce, data_we, data_line;
    logic inst_ce, inst_we, inst_line;
    addr_t data_addr, inst_addr;
    line_t data_wdata, inst_wdata, data_rdata, inst_rdata;
    line_strb_t data_wmask, inst_wmask;
    logic data_rdata_valid, data_write_finish, inst_rdata_valid, inst_write_finish;
    logic ar_valid, ar_ready, r_valid, r_ready, r_last;
    logic aw_valid, aw_ready, w_valid, w_ready, w_last, b_valid, b_ready;
    addr_t ar_addr, aw_addr;
    axi_len_t ar_len, aw_len;
    beat_t r_data, w_data;
    strb_t w_strb;

    beat_t shadow [256];
    int seed = 32'hb54b;
    int errors = 0;
    int test_num = 0;
    int tests_ok = 0;
    int cycles = 0;
    // pending kind per port: 0 none, 1 read, 2 write
    int data_pend = 0;
    int inst_pend = 0;
    line_t exp_data;
    line_t exp_inst;
    port_sel_t done_order [$];

    tb_clock_gen u_clk (.aclk(aclk), .reset(reset));

    sram_axi_bridge DUT (.*);

    axi_mem_model u_mem (.*);

    initial begin
        for (int i = 0; i < 256; i++) begin
            shadow[i] = 32'hc3a50000 + (i * 32'h00010001);
        end
    end

    // expected result for an address from the shadow memory
    function automatic line_t ref_read(addr_t addr, logic line);
        line_t r;
        int idx;
        r = '0;
        idx = int'(addr[9:2]);
        if (line) begin
            for (int i = 0; i < BEATS_PER_LINE; i++) begin
                r[i*32 +: 32] = shadow[(idx + i) & 255];
            end
        end else begin
            r[31:0] = shadow[idx];
        end
        return r;
    endfunction

    // byte merge by mask, single writes use beat 0
    function automatic void apply_write(addr_t addr, logic line, line_t wd, line_strb_t wm);
        int idx;
        int nbeats;
        idx = int'(addr[9:2]);
        nbeats = line ? BEATS_PER_LINE : 1;
        for (int b = 0; b < nbeats; b++) begin
            for (int k = 0; k < 4; k++) begin
                if (wm[b*4 + k]) begin
                    shadow[(idx + b) & 255][k*8 +: 8] = wd[b*32 + k*8 +: 8];
                end
            end
        end
    endfunction

    task automatic check_value(input string name, input line_t got, input line_t exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("Error: %s", what);
    endtask

    task automatic finish_test(input string name, input int err_before);
        test_num++;
        if (errors == err_before) begin
            tests_ok++;
            $display("test %0d %s: ok", test_num, name);
        end else begin
            $display("test %0d %s: %0d errors", test_num, name, errors - err_before);
        end
    endtask

    // one host transaction, holds ce until its own completion pulse
    task automatic run_txn(input port_sel_t port, input logic we, input logic line,
                           input addr_t addr, input line_t wd, input line_strb_t wm);
        @(negedge aclk);
        if (port == PORT_DATA) begin
            exp_data = ref_read(addr, line);
            data_pend = we ? 2 : 1;
            data_we = we;
            data_line = line;
            data_addr = addr;
            data_wdata = wd;
            data_wmask = wm;
            data_ce = 1'b1;
            do @(negedge aclk); while (!(data_rdata_valid || data_write_finish));
            data_ce = 1'b0;
        end else begin
            exp_inst = ref_read(addr, line);
            inst_pend = we ? 2 : 1;
            inst_we = we;
            inst_line = line;
            inst_addr = addr;
            inst_wdata = wd;
            inst_wmask = wm;
            inst_ce = 1'b1;
            do @(negedge aclk); while (!(inst_rdata_valid || inst_write_finish));
            inst_ce = 1'b0;
        end
        if (we) begin
            apply_write(addr, line, wd, wm);
        end
        @(posedge aclk);
        if (port == PORT_DATA) begin
            data_pend = 0;
        end else begin
            inst_pend = 0;
        end
    endtask

    // compare at the falling edge where completions are stable
    always @(negedge aclk) begin
        if (reset) begin
            if (data_rdata_valid || data_write_finish) begin
                done_order.push_back(PORT_DATA);
            end
            if (inst_rdata_valid || inst_write_finish) begin
                done_order.push_back(PORT_INST);
            end
            if (data_rdata_valid) begin
                if (data_pend != 1) begin
                    report_error("data port rdata_valid without a pending read");
                end else begin
                    check_value("data_rdata", data_rdata, exp_data);
                end
            end
            if (data_write_finish && data_pend != 2) begin
                report_error("data port write_finish without a pending write");
            end
            if (inst_rdata_valid) begin
                if (inst_pend != 1) begin
                    report_error("inst port rdata_valid without a pending read");
                end else begin
                    check_value("inst_rdata", inst_rdata, exp_inst);
                end
            end
            if (inst_write_finish && inst_pend != 2) begin
                report_error("inst port write_finish without a pending write");
            end
        end
    end

    always @(posedge aclk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    initial begin
        int e0;
        int nrand;
        port_sel_t p;
        logic we;
        logic ln;
        addr_t a;
        line_t wd;
        line_strb_t wm;
        data_ce = 1'b0;
        data_we = 1'b0;
        data_line = 1'b0;
        data_addr = '0;
        data_wdata = '0;
        data_wmask = '0;
        inst_ce = 1'b0;
        inst_we = 1'b0;
        inst_line = 1'b0;
        inst_addr = '0;
        inst_wdata = '0;
        inst_wmask = '0;
        wait (reset === 1'b1);

        // idle after reset
        e0 = errors;
        repeat (6) begin
            @(negedge aclk);
            check_value("ar_valid aw_valid w_valid r_ready b_ready completions",
                line_t'({ar_valid, aw_valid, w_valid, r_ready, b_ready, data_rdata_valid,
                          data_write_finish, inst_rdata_valid, inst_write_finish}), '0);
        end
        finish_test("idle after reset", e0);

        e0 = errors;
        run_txn(PORT_DATA, 1'b1, 1'b0, 32'h40, {96'h111122223333444455556666, 32'hdeadbeef},
                16'hfff0 | 16'h000f);
        run_txn(PORT_DATA, 1'b0, 1'b0, 32'h40, '0, '0);
        finish_test("single write then read", e0);

        e0 = errors;
        run_txn(PORT_DATA, 1'b1, 1'b1, 32'h100,
                128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0, 16'ha5c3);
        run_txn(PORT_INST, 1'b0, 1'b1, 32'h100, '0, '0);
        finish_test("masked line write, inst line read", e0);

        e0 = errors;
        done_order.delete();
        fork
            run_txn(PORT_DATA, 1'b0, 1'b1, 32'h200, '0, '0);
            run_txn(PORT_INST, 1'b0, 1'b1, 32'h300, '0, '0);
        join
        if (done_order.size() != 2 || done_order[0] != PORT_DATA) begin
            report_error("data completion did not arrive before inst completion");
        end
        finish_test("simultaneous requests", e0);

        e0 = errors;
        for (nrand = 0; nrand < 40; nrand++) begin
            p = (($random(seed) & 1) != 0) ? PORT_INST : PORT_DATA;
            we = (($random(seed) & 1) != 0);
            ln = (($random(seed) & 1) != 0);
            a = addr_t'($random(seed)) & (ln ? 32'h3f0 : 32'h3fc);
            wd = {beat_t'($random(seed)), beat_t'($random(seed)),
                  beat_t'($random(seed)), beat_t'($random(seed))};
            wm = line_strb_t'($random(seed));
            run_txn(p, we, ln, a, wd, wm);
        end
        // read back every word once
        for (nrand = 0; nrand < 64; nrand++) begin
            run_txn(PORT_DATA, 1'b0, 1'b1, addr_t'(nrand * 16), '0, '0);
        end
        finish_test("random mixed traffic", e0);

        $display("tests: %0d run, %0d ok, %0d errors", test_num, tests_ok, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/bridge_pkg.sv
`default_nettype none

package bridge_pkg;

    // bus widths
    localparam int ADDR_BITS = 32;
    localparam int BEAT_BITS = 32;
    localparam int STRB_BITS = BEAT_BITS / 8;
    localparam int BEATS_PER_LINE = 4;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [BEAT_BITS-1:0] beat_t;
    typedef logic [STRB_BITS-1:0] strb_t;
    // beat 0 in the low bits
    typedef logic [BEATS_PER_LINE*BEAT_BITS-1:0] line_t;
    typedef logic [BEATS_PER_LINE*STRB_BITS-1:0] line_strb_t;
    typedef logic [$clog2(BEATS_PER_LINE)-1:0] beat_cnt_t;
    typedef logic [7:0] axi_len_t;

    // AXI len field is beats minus one
    localparam axi_len_t LEN_SINGLE = 8'd0;
    localparam axi_len_t LEN_LINE = axi_len_t'(BEATS_PER_LINE - 1);

    // granted host
    typedef enum logic {
        PORT_DATA,
        PORT_INST
    } port_sel_t;

endpackage

`default_nettype wire

//--- rtl/port_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module port_arbiter (
    input  logic                   aclk,
    input  logic                   reset,
    // data host
    input  logic                   data_ce,
    input  logic                   data_we,
    input  logic                   data_line,
    input  bridge_pkg::addr_t      data_addr,
    input  bridge_pkg::line_t      data_wdata,
    input  bridge_pkg::line_strb_t data_wmask,
    output bridge_pkg::line_t      data_rdata,
    output logic                   data_rdata_valid,
    output logic                   data_write_finish,
    // inst host
    input  logic                   inst_ce,
    input  logic                   inst_we,
    input  logic                   inst_line,
    input  bridge_pkg::addr_t      inst_addr,
    input  bridge_pkg::line_t      inst_wdata,
    input  bridge_pkg::line_strb_t inst_wmask,
    output bridge_pkg::line_t      inst_rdata,
    output logic                   inst_rdata_valid,
    output logic                   inst_write_finish,
    // engines
    rd_req_if.arbiter              rd,
    wr_req_if.arbiter              wr
);
    import bridge_pkg::*;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_START,
        ARB_WAIT
    } arb_state_t;

    arb_state_t state;
    port_sel_t  sel;
    logic       req_we;
    logic       req_line;
    addr_t      req_addr;
    line_t      req_wdata;
    line_strb_t req_wmask;
    logic       start;

    // grant FSM, data wins when both ce are high
    always_ff @(posedge aclk) begin
        if (!reset) begin
            state <= ARB_IDLE;
            sel <= PORT_DATA;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (data_ce) begin
                        sel <= PORT_DATA;
                        state <= ARB_START;
                    end else if (inst_ce) begin
                        sel <= PORT_INST;
                        state <= ARB_START;
                    end
                end
                // start pulses here
                ARB_START: state <= ARB_WAIT;
                ARB_WAIT: begin
                    // back to idle after the completion cycle
                    if (rd.done || wr.done) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // capture the winning port's request fields
    always_ff @(posedge aclk) begin
        if (state == ARB_IDLE) begin
            if (data_ce) begin
                req_we <= data_we;
                req_line <= data_line;
                req_addr <= data_addr;
                req_wdata <= data_wdata;
                req_wmask <= data_wmask;
            end else begin
                req_we <= inst_we;
                req_line <= inst_line;
                req_addr <= inst_addr;
                req_wdata <= inst_wdata;
                req_wmask <= inst_wmask;
            end
        end
    end

    assign start = (state == ARB_START);

    // read engine request
    assign rd.start = start && !req_we;
    assign rd.addr = req_addr;
    assign rd.line = req_line;

    // write engine request
    assign wr.start = start && req_we;
    assign wr.addr = req_addr;
    assign wr.line = req_line;
    assign wr.wdata = req_wdata;
    assign wr.wmask = req_wmask;

    // route completions back to the granted host
    assign data_rdata = rd.rdata;
    assign inst_rdata = rd.rdata;
    assign data_rdata_valid = rd.done && (sel == PORT_DATA);
    assign inst_rdata_valid = rd.done && (sel == PORT_INST);
    assign data_write_finish = wr.done && (sel == PORT_DATA);
    assign inst_write_finish = wr.done && (sel == PORT_INST);

endmodule

`default_nettype wire

//--- rtl/rd_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface rd_req_if;
    import bridge_pkg::*;

    // request side, start is a one-cycle pulse
    logic  start;
    addr_t addr;
    logic  line;
    // completion side
    logic  done;
    line_t rdata;

    modport arbiter (output start, addr, line, input done, rdata);

    modport engine (input start, addr, line, output done, rdata);

endinterface

`default_nettype wire

//--- rtl/read_engine.sv
`timescale 1ns/1ps
`default_nettype none

module read_engine (
    input  logic                 aclk,
    input  logic                 reset,
    rd_req_if.engine             req,
    // AR channel
    output logic                 ar_valid,
    input  logic                 ar_ready,
    output bridge_pkg::addr_t    ar_addr,
    output bridge_pkg::axi_len_t ar_len,
    // R channel
    input  logic                 r_valid,
    output logic                 r_ready,
    input  bridge_pkg::beat_t    r_data,
    input  logic                 r_last
);
    import bridge_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA,
        RD_DONE
    } rd_state_t;

    rd_state_t state;
    beat_cnt_t beat_cnt;
    line_t     line_buf;
    logic      ar_hs;
    logic      r_hs;

    assign ar_hs = ar_valid && ar_ready;
    assign r_hs = r_valid && r_ready;

    // ready from start until the last beat
    assign r_ready = req.start || (state == RD_ADDR) || (state == RD_DATA);

    always_ff @(posedge aclk) begin
        if (!reset) begin
            state <= RD_IDLE;
            ar_valid <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (req.start) begin
                        ar_valid <= 1'b1;
                        state <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (ar_hs) begin
                        ar_valid <= 1'b0;
                        state <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    if (r_hs && r_last) begin
                        state <= RD_DONE;
                    end
                end
                // done pulse, line is complete
                RD_DONE: state <= RD_IDLE;
                default: state <= RD_IDLE;
            endcase
        end
    end

    // beat slot pointer
    always_ff @(posedge aclk) begin
        if (!reset) begin
            beat_cnt <= '0;
        end else if (req.start) begin
            beat_cnt <= '0;
        end else if (r_hs) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // address phase fields, held while ar_valid is up
    always_ff @(posedge aclk) begin
        if (req.start) begin
            ar_addr <= req.addr;
            ar_len <= req.line ? LEN_LINE : LEN_SINGLE;
        end
    end

    // clear on start so a single read leaves the upper beats zero
    always_ff @(posedge aclk) begin
        if (req.start) begin
            line_buf <= '0;
        end else if (r_hs) begin
            line_buf[beat_cnt*BEAT_BITS +: BEAT_BITS] <= r_data;
        end
    end

    assign req.done = (state == RD_DONE);
    assign req.rdata = line_buf;

endmodule

`default_nettype wire

//--- rtl/sram_axi_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module sram_axi_bridge (
    input  logic                   aclk,
    input  logic                   reset,
    // data host
    input  logic                   data_ce,
    input  logic                   data_we,
    input  logic                   data_line,
    input  bridge_pkg::addr_t      data_addr,
    input  bridge_pkg::line_t      data_wdata,
    input  bridge_pkg::line_strb_t data_wmask,
    output bridge_pkg::line_t      data_rdata,
    output logic                   data_rdata_valid,
    output logic                   data_write_finish,
    // inst host
    input  logic                   inst_ce,
    input  logic                   inst_we,
    input  logic                   inst_line,
    input  bridge_pkg::addr_t      inst_addr,
    input  bridge_pkg::line_t      inst_wdata,
    input  bridge_pkg::line_strb_t inst_wmask,
    output bridge_pkg::line_t      inst_rdata,
    output logic                   inst_rdata_valid,
    output logic                   inst_write_finish,
    // AR
    output logic                   ar_valid,
    input  logic                   ar_ready,
    output bridge_pkg::addr_t      ar_addr,
    output bridge_pkg::axi_len_t   ar_len,
    // R
    input  logic                   r_valid,
    output logic                   r_ready,
    input  bridge_pkg::beat_t      r_data,
    input  logic                   r_last,
    // AW
    output logic                   aw_valid,
    input  logic                   aw_ready,
    output bridge_pkg::addr_t      aw_addr,
    output bridge_pkg::axi_len_t   aw_len,
    // W
    output logic                   w_valid,
    input  logic                   w_ready,
    output bridge_pkg::beat_t      w_data,
    output bridge_pkg::strb_t      w_strb,
    output logic                   w_last,
    // B
    input  logic                   b_valid,
    output logic                   b_ready
);

    rd_req_if rd_bus ();
    wr_req_if wr_bus ();

    // one transaction at a time, data port first
    port_arbiter u_arbiter (
        .aclk(aclk), .reset(reset),
        .data_ce(data_ce), .data_we(data_we), .data_line(data_line),
        .data_addr(data_addr), .data_wdata(data_wdata), .data_wmask(data_wmask),
        .data_rdata(data_rdata), .data_rdata_valid(data_rdata_valid),
        .data_write_finish(data_write_finish),
        .inst_ce(inst_ce), .inst_we(inst_we), .inst_line(inst_line),
        .inst_addr(inst_addr), .inst_wdata(inst_wdata), .inst_wmask(inst_wmask),
        .inst_rdata(inst_rdata), .inst_rdata_valid(inst_rdata_valid),
        .inst_write_finish(inst_write_finish),
        .rd(rd_bus.arbiter), .wr(wr_bus.arbiter)
    );

    // AR and R
    read_engine u_read (
        .aclk(aclk), .reset(reset), .req(rd_bus.engine),
        .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr), .ar_len(ar_len),
        .r_valid(r_valid), .r_ready(r_ready), .r_data(r_data), .r_last(r_last)
    );

    // AW, W and B
    write_engine u_write (
        .aclk(aclk), .reset(reset), .req(wr_bus.engine),
        .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr), .aw_len(aw_len),
        .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data), .w_strb(w_strb),
        .w_last(w_last),
        .b_valid(b_valid), .b_ready(b_ready)
    );

endmodule

`default_nettype wire

//--- rtl/wr_req_if.sv
`timescale 1ns/1ps
`default_nettype none

interface wr_req_if;
    import bridge_pkg::*;

    // request side, start is a one-cycle pulse
    logic       start;
    addr_t      addr;
    logic       line;
    line_t      wdata;
    line_strb_t wmask;
    // completion pulse after B
    logic       done;

    modport arbiter (output start, addr, line, wdata, wmask, input done);

    modport engine (input start, addr, line, wdata, wmask, output done);

endinterface

`default_nettype wire

//--- rtl/write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module write_engine (
    input  logic                 aclk,
    input  logic                 reset,
    wr_req_if.engine             req,
    // AW channel
    output logic                 aw_valid,
    input  logic                 aw_ready,
    output bridge_pkg::addr_t    aw_addr,
    output bridge_pkg::axi_len_t aw_len,
    // W channel
    output logic                 w_valid,
    input  logic                 w_ready,
    output bridge_pkg::beat_t    w_data,
    output bridge_pkg::strb_t    w_strb,
    output logic                 w_last,
    // B channel
    input  logic                 b_valid,
    output logic                 b_ready
);
    import bridge_pkg::*;

    // AW and W finish in either order
    typedef enum logic [2:0] {
        WR_IDLE,
        WR_BOTH,
        WR_W_ONLY,
        WR_AW_ONLY,
        WR_RESP,
        WR_DONE
    } wr_state_t;

    wr_state_t  state;
    beat_cnt_t  beat_cnt;
    line_t      data_buf;
    line_strb_t mask_buf;
    logic       aw_hs;
    logic       w_hs;
    logic       w_fin;
    logic       b_hs;

    assign aw_hs = aw_valid && aw_ready;
    assign w_hs = w_valid && w_ready;
    assign w_fin = w_hs && w_last;
    assign b_hs = b_valid && b_ready;

    // only after both AW and the last W
    assign b_ready = (state == WR_RESP);

    always_ff @(posedge aclk) begin
        if (!reset) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (req.start) begin
                        state <= WR_BOTH;
                    end
                end
                WR_BOTH: begin
                    if (aw_hs && w_fin) begin
                        state <= WR_RESP;
                    end else if (aw_hs) begin
                        state <= WR_W_ONLY;
                    end else if (w_fin) begin
                        state <= WR_AW_ONLY;
                    end
                end
                // AW accepted, beats still going out
                WR_W_ONLY: begin
                    if (w_fin) begin
                        state <= WR_RESP;
                    end
                end
                // all beats out, AW still pending
                WR_AW_ONLY: begin
                    if (aw_hs) begin
                        state <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (b_hs) begin
                        state <= WR_DONE;
                    end
                end
                WR_DONE: state <= WR_IDLE;
                default: state <= WR_IDLE;
            endcase
        end
    end

    // valid flags and beat tracking
    always_ff @(posedge aclk) begin
        if (!reset) begin
            aw_valid <= 1'b0;
            w_valid <= 1'b0;
            w_last <= 1'b0;
            beat_cnt <= '0;
        end else if (req.start) begin
            aw_valid <= 1'b1;
            w_valid <= 1'b1;
            // a single write is its own last beat
            w_last <= !req.line;
            beat_cnt <= '0;
        end else begin
            if (aw_hs) begin
                aw_valid <= 1'b0;
            end
            if (w_fin) begin
                w_valid <= 1'b0;
                w_last <= 1'b0;
            end else if (w_hs) begin
                beat_cnt <= beat_cnt + 1'b1;
                // next beat is beat 3
                w_last <= (beat_cnt == beat_cnt_t'(BEATS_PER_LINE - 2));
            end
        end
    end

    // address fields
    always_ff @(posedge aclk) begin
        if (req.start) begin
            aw_addr <= req.addr;
            aw_len <= req.line ? LEN_LINE : LEN_SINGLE;
        end
    end

    // beat 0 goes out first, the rest shift down per W handshake
    always_ff @(posedge aclk) begin
        if (req.start) begin
            w_data <= req.wdata[BEAT_BITS-1:0];
            w_strb <= req.wmask[STRB_BITS-1:0];
            data_buf <= req.wdata >> BEAT_BITS;
            mask_buf <= req.wmask >> STRB_BITS;
        end else if (w_hs && !w_last) begin
            w_data <= data_buf[BEAT_BITS-1:0];
            w_strb <= mask_buf[STRB_BITS-1:0];
            data_buf <= data_buf >> BEAT_BITS;
            mask_buf <= mask_buf >> STRB_BITS;
        end
    end

    // one cycle after B
    assign req.done = (state == WR_DONE);

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the bridge testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    -f build.f \
    --top-module tb_sram_axi_bridge \
    -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Testbench failed" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

echo "simulation finished without failure"
exit 0
